/* include/exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Data path width.
`define WORD_W 32

// Reorder-buffer tag width.
`define TAG_W 5

// Number of words on the bypass bus.
`define FWD_NUM 4

`endif

/* design/exec_pkg.sv */
`include "exec_macros.svh"

package exec_pkg;

    localparam int FWD_IDX_W = $clog2(`FWD_NUM);

    typedef enum logic [1:0] {UNIT_ALU, UNIT_BRANCH, UNIT_MEM} unit_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL
    } alu_op_e;

    typedef enum logic [1:0] {BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ} branch_type_e;

    typedef enum logic {SRC_REG, SRC_IMM} alusrc_e;

    // ----------------------------------------
    // Control word, two views of six bits.
    // ----------------------------------------
    typedef struct packed {
        alu_op_e alu_op;
        alusrc_e alusrc;
        logic    memtoreg;
        logic    memwrite;
    } mem_ctl_t;

    typedef struct packed {
        logic [3:0]   pad;
        branch_type_e branch_type;
    } branch_ctl_t;

    typedef union packed {
        mem_ctl_t    mem;
        branch_ctl_t br;
    } ctl_u;

    // ----------------------------------------
    // Issue, bypass and decoded request.
    // ----------------------------------------
    typedef struct packed {
        logic                 valid;
        unit_e                unit;
        ctl_u                 ctl;
        logic [`WORD_W-1:0]   src1;
        logic [`WORD_W-1:0]   src2;
        logic [`WORD_W-1:0]   imm;
        logic [`WORD_W-1:0]   pcplus8;
        logic [`TAG_W-1:0]    dst;
        logic                 fw1_valid;
        logic [FWD_IDX_W-1:0] fw1;
        logic                 fw2_valid;
        logic [FWD_IDX_W-1:0] fw2;
    } issue_t;

    typedef struct packed {
        logic [`FWD_NUM-1:0][`WORD_W-1:0] data;
    } bypass_t;

    typedef struct packed {
        logic               valid;
        unit_e              unit;
        ctl_u               ctl;
        logic [`WORD_W-1:0] a;
        logic [`WORD_W-1:0] b;
        logic [`WORD_W-1:0] store_data;
        logic [`WORD_W-1:0] imm;
        logic [`WORD_W-1:0] pcplus8;
        logic [`TAG_W-1:0]  dst;
    } exec_req_t;

    // ----------------------------------------
    // Commit word and Wishbone master outputs.
    // ----------------------------------------
    typedef struct packed {
        logic [`TAG_W-1:0]  rob_tag;
        logic [`WORD_W-1:0] data;
        logic [`WORD_W-1:0] addr;
        logic               branch_taken;
        logic [`WORD_W-1:0] pcbranch;
        logic               exc_of;
        logic               exc_load;
        logic               exc_save;
    } commit_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WORD_W-1:0]   adr;
        logic [`WORD_W-1:0]   dat_w;
        logic [`WORD_W/8-1:0] sel;
    } wb_req_t;

endpackage

/* design/issue_decode.sv */
`include "exec_macros.svh"

module issue_decode (
    input  exec_pkg::issue_t    issue,
    input  exec_pkg::bypass_t   bypass,
    output exec_pkg::exec_req_t exec_req
);
    import exec_pkg::*;

    logic [`WORD_W-1:0] opa;
    logic [`WORD_W-1:0] opb;

    // A valid hint overrides the register operand.
    assign opa = issue.fw1_valid ? bypass.data[issue.fw1] : issue.src1;
    assign opb = issue.fw2_valid ? bypass.data[issue.fw2] : issue.src2;

    always_comb begin
        exec_req.valid      = issue.valid;
        exec_req.unit       = issue.unit;
        exec_req.ctl        = issue.ctl;
        exec_req.a          = opa;
        exec_req.b          = opb;
        exec_req.store_data = '0;
        exec_req.imm        = issue.imm;
        exec_req.pcplus8    = issue.pcplus8;
        exec_req.dst        = issue.dst;

        case (issue.unit)
            UNIT_ALU: begin
                if (issue.ctl.mem.alusrc == SRC_IMM) begin
                    exec_req.b = issue.imm;
                end
            end
            UNIT_MEM: begin
                // Base plus offset, src2 is the store word.
                exec_req.b          = issue.imm;
                exec_req.store_data = opb;
            end
            UNIT_BRANCH: begin
                exec_req.ctl                = '0;
                exec_req.ctl.br.branch_type = issue.ctl.br.branch_type;
            end
            default: begin
                exec_req.b = opb;
            end
        endcase
    end

endmodule

/* design/alu_unit.sv */
`include "exec_macros.svh"

module alu_unit (
    input  exec_pkg::exec_req_t req,
    output logic [`WORD_W-1:0]  result,
    output logic                overflow
);
    import exec_pkg::*;

    localparam int MSB = `WORD_W - 1;

    logic [`WORD_W-1:0] sum;
    logic [`WORD_W-1:0] diff;

    assign sum  = req.a + req.b;
    assign diff = req.a - req.b;

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (req.ctl.mem.alu_op)
            ALU_ADD: begin
                result   = sum;
                // Same operand signs, result sign flipped.
                overflow = (req.a[MSB] == req.b[MSB]) && (sum[MSB] != req.a[MSB]);
            end
            ALU_SUB: begin
                result   = diff;
                overflow = (req.a[MSB] != req.b[MSB]) && (diff[MSB] != req.a[MSB]);
            end
            ALU_AND: result = req.a & req.b;
            ALU_OR:  result = req.a | req.b;
            ALU_XOR: result = req.a ^ req.b;
            ALU_SLT: begin
                result = {{MSB{1'b0}}, $signed(req.a) < $signed(req.b)};
            end
            ALU_SLL: result = req.a << req.b[4:0];
            default: begin
                result   = '0;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

/* design/branch_unit.sv */
`include "exec_macros.svh"

module branch_unit (
    input  exec_pkg::exec_req_t req,
    output logic                taken,
    output logic [`WORD_W-1:0]  target
);
    import exec_pkg::*;

    logic signed [`WORD_W-1:0] sa;
    logic signed [`WORD_W-1:0] sb;

    assign sa = req.a;
    assign sb = req.b;

    always_comb begin
        case (req.ctl.br.branch_type)
            BR_BEQ:  taken = (sa == sb);
            BR_BNE:  taken = (sa != sb);
            BR_BLEZ: taken = (sa <= 0);
            BR_BGTZ: taken = (sa > 0);
            default: taken = 1'b0;
        endcase
    end

    // Delay slot address plus word offset.
    assign target = req.pcplus8 - `WORD_W'(4) + {req.imm[`WORD_W-3:0], 2'b00};

endmodule

/* design/load_store_unit.sv */
`include "exec_macros.svh"

module load_store_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  exec_pkg::exec_req_t   req,
    input  logic                  accept,
    output exec_pkg::wb_req_t     wb,
    input  logic                  wb_ack,
    input  logic [`WORD_W-1:0]    wb_dat_r,
    output logic                  mem_busy,
    output logic                  mem_done,
    output exec_pkg::commit_t     mem_result
);
    import exec_pkg::*;

    logic [`WORD_W-1:0] addr;
    logic               start;
    logic               misaligned;
    logic               cyc_q;
    logic               we_q;
    logic [`WORD_W-1:0] dat_q;

    assign addr       = req.a + req.b;
    assign start      = accept && (req.unit == UNIT_MEM);
    assign misaligned = (addr[1:0] != 2'b00);

    // ----------------------------------------
    // Bus cycle control.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q    <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (cyc_q) begin
                if (wb_ack) begin
                    cyc_q    <= 1'b0;
                    mem_done <= 1'b1;
                end
            end else if (start) begin
                if (misaligned) begin
                    mem_done <= 1'b1;
                end else begin
                    cyc_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!cyc_q && start) begin
            we_q                    <= req.ctl.mem.memwrite;
            dat_q                   <= req.store_data;
            mem_result.rob_tag      <= req.dst;
            mem_result.addr         <= addr;
            mem_result.data         <= '0;
            mem_result.branch_taken <= 1'b0;
            mem_result.pcbranch     <= '0;
            mem_result.exc_of       <= 1'b0;
            mem_result.exc_load     <= misaligned && req.ctl.mem.memtoreg;
            mem_result.exc_save     <= misaligned && req.ctl.mem.memwrite;
        end else if (cyc_q && wb_ack && !we_q) begin
            mem_result.data <= wb_dat_r;
        end
    end

    always_comb begin
        wb.cyc   = cyc_q;
        wb.stb   = cyc_q;
        wb.we    = we_q;
        wb.adr   = mem_result.addr;
        wb.dat_w = dat_q;
        wb.sel   = '1;
    end

    // Also busy while the finished result is handed over.
    assign mem_busy = cyc_q || mem_done;

endmodule

/* design/commit_result.sv */
`include "exec_macros.svh"

module commit_result (
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::exec_req_t exec_req,
    input  logic [`WORD_W-1:0]  alu_result,
    input  logic                alu_overflow,
    input  logic                br_taken,
    input  logic [`WORD_W-1:0]  br_target,
    input  logic                mem_busy,
    input  logic                mem_done,
    input  exec_pkg::commit_t   mem_result,
    output logic                accept,
    output logic                issue_ready,
    output logic                commit_valid,
    output exec_pkg::commit_t   commit,
    input  logic                commit_ready
);
    import exec_pkg::*;

    logic    fast_op;
    commit_t fast_word;

    assign issue_ready = !mem_busy && !(commit_valid && !commit_ready);
    assign accept      = exec_req.valid && issue_ready;
    assign fast_op     = accept && (exec_req.unit != UNIT_MEM);

    always_comb begin
        fast_word          = '0;
        fast_word.rob_tag  = exec_req.dst;
        if (exec_req.unit == UNIT_BRANCH) begin
            fast_word.branch_taken = br_taken;
            fast_word.pcbranch     = br_target;
        end else begin
            fast_word.data   = alu_result;
            fast_word.exc_of = alu_overflow;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else if (fast_op || mem_done) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    // Loads only when the slot is free or drains this cycle.
    always_ff @(posedge clk) begin
        if (fast_op) begin
            commit <= fast_word;
        end else if (mem_done) begin
            commit <= mem_result;
        end
    end

endmodule

/* design/exec_cluster.sv */
`include "exec_macros.svh"

module exec_cluster (
    input  logic               clk,
    input  logic               rst,
    input  exec_pkg::issue_t   issue,
    input  exec_pkg::bypass_t  bypass,
    output logic               issue_ready,
    output logic               commit_valid,
    output exec_pkg::commit_t  commit,
    input  logic               commit_ready,
    output exec_pkg::wb_req_t  wb,
    input  logic               wb_ack,
    input  logic [`WORD_W-1:0] wb_dat_r
);
    import exec_pkg::*;

    exec_req_t          exec_req;
    logic [`WORD_W-1:0] alu_result;
    logic               alu_overflow;
    logic               br_taken;
    logic [`WORD_W-1:0] br_target;
    logic               accept;
    logic               mem_busy;
    logic               mem_done;
    commit_t            mem_result;

    issue_decode u_decode (
        .issue    (issue),
        .bypass   (bypass),
        .exec_req (exec_req)
    );

    alu_unit u_alu (
        .req      (exec_req),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    branch_unit u_branch (
        .req    (exec_req),
        .taken  (br_taken),
        .target (br_target)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .rst        (rst),
        .req        (exec_req),
        .accept     (accept),
        .wb         (wb),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .mem_busy   (mem_busy),
        .mem_done   (mem_done),
        .mem_result (mem_result)
    );

    commit_result u_commit (
        .clk          (clk),
        .rst          (rst),
        .exec_req     (exec_req),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow),
        .br_taken     (br_taken),
        .br_target    (br_target),
        .mem_busy     (mem_busy),
        .mem_done     (mem_done),
        .mem_result   (mem_result),
        .accept       (accept),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

/* tb/exec_cluster_assertions.sv */
`include "exec_macros.svh"

module exec_cluster_assertions (
    input logic                clk,
    input logic                rst,
    input exec_pkg::issue_t    issue,
    input exec_pkg::bypass_t   bypass,
    input logic                issue_ready,
    input logic                commit_valid,
    input exec_pkg::commit_t   commit,
    input logic                commit_ready,
    input exec_pkg::wb_req_t   wb,
    input logic                wb_ack
);
    timeunit 1ns;
    timeprecision 1ns;
    import exec_pkg::*;

    localparam logic [`WORD_W-1:0] READ_PATTERN = 32'hA5A5_0F0F;

    int                 fail_count = 0;
    commit_t            exp_mem [4];
    commit_t            exp_head;
    commit_t            cur;
    logic [1:0]         rd_ptr;
    logic [1:0]         wr_ptr;
    logic [2:0]         exp_cnt;
    logic               accept;
    logic               xfer;
    logic [`WORD_W-1:0] store_word;
    logic [`WORD_W-1:0] exp_adr;
    logic [`WORD_W-1:0] exp_dat;
    logic               exp_we;

    function automatic commit_t expect_commit(issue_t op, bypass_t byp);
        commit_t            c;
        logic [`WORD_W-1:0] x;
        logic [`WORD_W-1:0] y;
        logic [`WORD_W-1:0] b;
        logic [`WORD_W:0]   wide;
        c = '0;
        c.rob_tag = op.dst;
        x = op.fw1_valid ? byp.data[op.fw1] : op.src1;
        y = op.fw2_valid ? byp.data[op.fw2] : op.src2;
        b = (op.ctl.mem.alusrc == SRC_IMM) ? op.imm : y;
        case (op.unit)
            UNIT_ALU: begin
                case (op.ctl.mem.alu_op)
                    ALU_ADD: c.data = x + b;
                    ALU_SUB: c.data = x - b;
                    ALU_AND: c.data = x & b;
                    ALU_OR:  c.data = x | b;
                    ALU_XOR: c.data = x ^ b;
                    ALU_SLT: c.data = ($signed(x) < $signed(b)) ? `WORD_W'(1) : `WORD_W'(0);
                    default: c.data = x << b[4:0];
                endcase
                // Overflow when the top two bits of the sign-extended sum differ.
                if (op.ctl.mem.alu_op == ALU_ADD) begin
                    wide = {x[`WORD_W-1], x} + {b[`WORD_W-1], b};
                    c.exc_of = wide[`WORD_W] != wide[`WORD_W-1];
                end else if (op.ctl.mem.alu_op == ALU_SUB) begin
                    wide = {x[`WORD_W-1], x} - {b[`WORD_W-1], b};
                    c.exc_of = wide[`WORD_W] != wide[`WORD_W-1];
                end
            end
            UNIT_BRANCH: begin
                case (op.ctl.br.branch_type)
                    BR_BEQ:  c.branch_taken = (x == y);
                    BR_BNE:  c.branch_taken = (x != y);
                    BR_BLEZ: c.branch_taken = ($signed(x) <= 0);
                    default: c.branch_taken = ($signed(x) > 0);
                endcase
                c.pcbranch = op.pcplus8 + (op.imm << 2) - `WORD_W'(4);
            end
            default: begin
                c.addr     = x + op.imm;
                c.exc_load = (c.addr[1:0] != 2'b00) && op.ctl.mem.memtoreg;
                c.exc_save = (c.addr[1:0] != 2'b00) && op.ctl.mem.memwrite;
                if (c.addr[1:0] == 2'b00 && !op.ctl.mem.memwrite) begin
                    c.data = c.addr ^ READ_PATTERN;
                end
            end
        endcase
        return c;
    endfunction

    assign cur        = expect_commit(issue, bypass);
    assign store_word = issue.fw2_valid ? bypass.data[issue.fw2] : issue.src2;
    assign accept     = issue.valid && issue_ready;
    assign xfer       = commit_valid && commit_ready;
    assign exp_head   = exp_mem[rd_ptr];

    // ----------------------------------------
    // Expected commit FIFO.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            exp_cnt <= '0;
        end else begin
            if (accept) begin
                exp_mem[wr_ptr] <= cur;
                wr_ptr          <= wr_ptr + 2'd1;
            end
            if (xfer) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            if (accept && !xfer) begin
                exp_cnt <= exp_cnt + 3'd1;
            end else if (xfer && !accept) begin
                exp_cnt <= exp_cnt - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && issue.unit == UNIT_MEM) begin
            exp_adr <= cur.addr;
            exp_we  <= issue.ctl.mem.memwrite;
            exp_dat <= store_word;
        end
    end

    // ----------------------------------------
    // Commit port.
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (rst)
        xfer |-> exp_cnt != 3'd0 && commit == exp_head)
        else begin $error("commit word differs from the issued op"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst)
        accept && issue.unit != UNIT_MEM |=> commit_valid)
        else begin $error("ALU or branch result is late"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst)
        commit_valid && !commit_ready |-> !issue_ready)
        else begin $error("issue accepted under back-pressure"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin $error("held commit changed"); fail_count++; end

    assert property (@(posedge clk)
        $fell(rst) |-> !commit_valid && !wb.cyc && issue_ready)
        else begin $error("wrong state after reset"); fail_count++; end

    // ----------------------------------------
    // Wishbone master.
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (rst)
        (wb.cyc || wb.stb) |-> wb.cyc && wb.stb && wb.sel == '1 && wb.adr == exp_adr
                               && wb.we == exp_we && (!exp_we || wb.dat_w == exp_dat))
        else begin $error("bus request does not match the memory op"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst)
        wb.cyc && !wb_ack |=> wb.cyc)
        else begin $error("cyc dropped before ack"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst)
        wb.cyc && wb_ack |=> !wb.cyc)
        else begin $error("cyc still high after ack"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst)
        wb.cyc |-> !commit_valid)
        else begin $error("memory op committed before its ack"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst)
        accept && issue.unit == UNIT_MEM && cur.addr[1:0] == 2'b00 |=> wb.cyc)
        else begin $error("aligned access started no bus cycle"); fail_count++; end

    assert property (@(posedge clk) disable iff (rst)
        accept && issue.unit == UNIT_MEM && cur.addr[1:0] != 2'b00 |=> !wb.cyc)
        else begin $error("misaligned access reached the bus"); fail_count++; end

endmodule

bind exec_cluster exec_cluster_assertions u_chk (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .bypass       (bypass),
    .issue_ready  (issue_ready),
    .commit_valid (commit_valid),
    .commit       (commit),
    .commit_ready (commit_ready),
    .wb           (wb),
    .wb_ack       (wb_ack)
);

/* tb/exec_cluster_tb.sv */
`include "exec_macros.svh"

module exec_cluster_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import exec_pkg::*;

    localparam int NUM_OPS = 400;
    localparam logic [`WORD_W-1:0] READ_PATTERN = 32'hA5A5_0F0F;

    logic               clk = 1'b0;
    logic               rst;
    issue_t             issue;
    bypass_t            bypass;
    logic               issue_ready;
    logic               commit_valid;
    commit_t            commit;
    logic               commit_ready = 1'b1;
    wb_req_t            wb;
    logic               wb_ack = 1'b0;
    logic [`WORD_W-1:0] wb_dat_r = '0;
    logic [31:0]        op_seed = 32'h7561;
    logic [31:0]        rdy_seed = 32'h7561 + 32'd1;
    logic [31:0]        mem_seed = 32'h7561 + 32'd2;
    logic [1:0]         wait_cnt = 2'd0;
    logic               mem_active = 1'b0;
    int                 commit_count = 0;

    exec_cluster UUT (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .bypass       (bypass),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .wb           (wb),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] op_rand();
        op_seed = lcg_step(op_seed);
        return op_seed;
    endfunction

    task automatic make_op();
        logic [31:0]        r;
        logic [`WORD_W-1:0] base;
        r = op_rand();
        issue           = '0;
        issue.valid     = 1'b1;
        issue.unit      = unit_e'(2'(r[31:16] % 16'd3));
        issue.ctl       = ctl_u'(r[5:0]);
        issue.fw1_valid = r[6];
        issue.fw1       = r[8:7];
        issue.fw2_valid = r[9];
        issue.fw2       = r[11:10];
        issue.dst       = r[16:12];
        issue.src1      = op_rand();
        issue.src2      = op_rand();
        r               = op_rand();
        issue.pcplus8   = {r[31:2], 2'b00};
        for (int k = 0; k < `FWD_NUM; k++) begin
            bypass.data[k] = op_rand();
        end
        r = op_rand();
        issue.imm = {{16{r[15]}}, r[15:0]};
        if (issue.unit == UNIT_ALU && issue.ctl.mem.alu_op == 3'd7) begin
            issue.ctl.mem.alu_op = ALU_SLL;
        end
        // Equal operands now and then so beq is taken.
        if (issue.unit == UNIT_BRANCH && r[20]) begin
            issue.src2      = issue.src1;
            issue.fw2_valid = issue.fw1_valid;
            issue.fw2       = issue.fw1;
        end
        if (issue.unit == UNIT_MEM) begin
            issue.ctl.mem.memtoreg = !issue.ctl.mem.memwrite;
            base      = issue.fw1_valid ? bypass.data[issue.fw1] : issue.src1;
            issue.imm = {{16{r[15]}}, r[15:2], 2'b00} - {30'd0, base[1:0]};
            if (r[18:16] == 3'd0) begin
                issue.imm = issue.imm + {30'd0, r[22:21] | 2'b01};
            end
        end
    endtask

    // Reorder buffer with random back-pressure.
    always @(posedge clk) begin
        #1;
        rdy_seed     = lcg_step(rdy_seed);
        commit_ready = rdy_seed[31:30] != 2'b00;
    end

    // ----------------------------------------
    // Wishbone memory with 0 to 3 wait states.
    // ----------------------------------------
    always @(posedge clk) begin
        #1;
        if (rst || wb_ack) begin
            wb_ack     = 1'b0;
            mem_active = 1'b0;
        end else if (wb.cyc && wb.stb) begin
            if (!mem_active) begin
                mem_seed   = lcg_step(mem_seed);
                wait_cnt   = mem_seed[31:30];
                mem_active = 1'b1;
            end
            if (wait_cnt == 2'd0) begin
                wb_ack   = 1'b1;
                wb_dat_r = wb.adr ^ READ_PATTERN;
            end else begin
                wait_cnt = wait_cnt - 2'd1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && commit_valid && commit_ready) begin
            commit_count++;
        end
        if (UUT.u_chk.fail_count != 0) begin
            $display("[ERROR] %0t ns: a bound assertion on the DUT failed", $time);
            $display("Some tests failed");
            $fatal(1, "stopped at the first failed check");
        end
    end

    initial begin
        #(NUM_OPS * 8 * 8);
        $display("Timeout: the ops did not all commit in time");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic accepted;
        rst    = 1'b1;
        issue  = '0;
        bypass = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_OPS; i++) begin
            make_op();
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = issue_ready;
                @(posedge clk);
                #1;
            end
            issue.valid = 1'b0;
        end
        while (commit_count < NUM_OPS) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        if (UUT.u_chk.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* flist.f */
+incdir+include
design/exec_pkg.sv
design/issue_decode.sv
design/alu_unit.sv
design/branch_unit.sv
design/load_store_unit.sv
design/commit_result.sv
design/exec_cluster.sv
tb/exec_cluster_assertions.sv
tb/exec_cluster_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f flist.f --top-module exec_cluster_tb \
    -o exec_cluster_sim \
    && ./obj_dir/exec_cluster_sim +verilator+error+limit+100 \
    || exit 1
